// ==== Bender.yml ====
package:
  name: maze_renderer

export_include_dirs:
  - hdl

sources:
  - files:
      - hdl/maze_geometry_pkg.sv
      - hdl/maze_colour_pkg.sv
      - hdl/cell_locator.sv
      - hdl/wall_decoder.sv
      - hdl/player_sprite_rom.sv
      - hdl/pixel_compositor.sv
      - hdl/maze_renderer.sv
  - target: test
    files:
      - verification/maze_renderer_tb.sv

// ==== compile.f ====
+incdir+hdl
hdl/maze_geometry_pkg.sv
hdl/maze_colour_pkg.sv
hdl/cell_locator.sv
hdl/wall_decoder.sv
hdl/player_sprite_rom.sv
hdl/pixel_compositor.sv
hdl/maze_renderer.sv
verification/maze_renderer_tb.sv

// ==== hdl/cell_locator.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "maze_params.svh"

module cell_locator (
    input  wire maze_geometry_pkg::pixel_coord_t pixel,
    input  wire maze_geometry_pkg::cell_num_t    position,
    output logic                                 in_cell,
    output maze_geometry_pkg::sprite_offset_t    offset
);
    import maze_geometry_pkg::*;

    logic [2:0] col;
    logic [1:0] row;
    coord_t     org_x;
    coord_t     org_y;
    coord_t     dx;
    coord_t     dy;

    // cells numbered row by row
    assign col = 3'(position % `MAZE_COLS);
    assign row = 2'(position / `MAZE_COLS);

    // top left corner of the player window
    assign org_x = COORD_W'(`MAZE_SPRITE_ORG_X + `MAZE_PITCH * col);
    assign org_y = COORD_W'(`MAZE_SPRITE_ORG_Y + `MAZE_PITCH * row);

    // wraps to a large value left of or above the origin
    assign dx = pixel.x - org_x;
    assign dy = pixel.y - org_y;

    // so a single upper compare per axis is enough
    assign in_cell = (dx < COORD_W'(`MAZE_SPRITE_SIZE)) &&
                     (dy < COORD_W'(`MAZE_SPRITE_SIZE));

    assign offset.px = OFFSET_W'(dx);
    assign offset.py = OFFSET_W'(dy);

    // cell numbers past the grid would place the window off the maze
    assert final ($isunknown(position) ||
                  position < CELL_W'(`MAZE_COLS * `MAZE_ROWS))
        else $error("player cell %0d lies outside the maze grid", position);

endmodule

`default_nettype wire

// ==== hdl/maze_colour_pkg.sv ====
`default_nettype none

package maze_colour_pkg;

    // rgb565, red in the top bits
    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } rgb565_t;

    // sprite palette indices
    typedef enum logic [2:0] {
        PAL_WHITE,
        PAL_BLACK,
        PAL_SKIN,
        PAL_HAIR,
        PAL_SHOE,
        PAL_CAP
    } palette_t;

    // one drawing layer's claim on a pixel
    typedef struct packed {
        logic    hit;
        rgb565_t colour;
    } layer_hit_t;

    // palette colours
    localparam rgb565_t COLOUR_WHITE = 16'hffff;
    localparam rgb565_t COLOUR_BLACK = 16'h0000;
    localparam rgb565_t COLOUR_SKIN  = 16'hcc88;
    localparam rgb565_t COLOUR_HAIR  = 16'hdd6e;
    localparam rgb565_t COLOUR_SHOE  = 16'h9346;
    localparam rgb565_t COLOUR_CAP   = 16'he803;

endpackage

`default_nettype wire

// ==== hdl/maze_geometry_pkg.sv ====
`default_nettype none

`include "maze_params.svh"

package maze_geometry_pkg;

    // axis width covers the larger panel side
    localparam int COORD_W = $clog2((`MAZE_PANEL_W > `MAZE_PANEL_H) ?
                                    `MAZE_PANEL_W : `MAZE_PANEL_H);
    // enough to address every cell
    localparam int CELL_W = $clog2(`MAZE_COLS * `MAZE_ROWS);
    // one bit per wall segment
    localparam int MAP_W = `MAZE_VWALLS + `MAZE_HWALLS;
    // offset inside the sprite window
    localparam int OFFSET_W = $clog2(`MAZE_SPRITE_SIZE);

    typedef logic [COORD_W-1:0] coord_t;

    // x in the upper half
    typedef struct packed {
        coord_t x;
        coord_t y;
    } pixel_coord_t;

    typedef logic [CELL_W-1:0] cell_num_t;

    // bits 0..15 vertical, 16..30 horizontal
    typedef logic [MAP_W-1:0] maze_map_t;

    typedef struct packed {
        logic [OFFSET_W-1:0] px;
        logic [OFFSET_W-1:0] py;
    } sprite_offset_t;

endpackage

`default_nettype wire

// ==== hdl/maze_params.svh ====
`ifndef MAZE_PARAMS_SVH
`define MAZE_PARAMS_SVH

//////////////////////////////////////////////////
// panel
//////////////////////////////////////////////////

// 96x64 oled, one pixel per clock
`define MAZE_PANEL_W 96
`define MAZE_PANEL_H 64

//////////////////////////////////////////////////
// maze grid
//////////////////////////////////////////////////

// 5 columns by 4 rows of cells
`define MAZE_COLS 5
`define MAZE_ROWS 4
// distance between wall lines
`define MAZE_PITCH 15

// outer frame, inclusive
`define MAZE_LEFT 11
`define MAZE_RIGHT 85
`define MAZE_TOP 2
`define MAZE_BOTTOM 61

// wall map split, vertical bits first
`define MAZE_VWALLS 16
`define MAZE_HWALLS 15

// player window relative to cell (0,0)
`define MAZE_SPRITE_ORG_X 13
`define MAZE_SPRITE_ORG_Y 3
`define MAZE_SPRITE_SIZE 15

`endif

// ==== hdl/maze_renderer.sv ====
`timescale 1ns/1ps
`default_nettype none

module maze_renderer (
    input  wire                                  clock,
    input  wire                                  reset,
    input  wire maze_geometry_pkg::pixel_coord_t pixel,
    input  wire maze_geometry_pkg::maze_map_t    maze,
    input  wire maze_geometry_pkg::cell_num_t    position,
    output maze_colour_pkg::rgb565_t             oled_data
);
    import maze_geometry_pkg::*;
    import maze_colour_pkg::*;

    // player window
    logic           in_cell;
    sprite_offset_t offset;
    // frame and wall layers
    layer_hit_t     border;
    layer_hit_t     wall;
    // sprite colour at the current offset
    rgb565_t        sprite;

    cell_locator u_cell_locator (
        .pixel    (pixel),
        .position (position),
        .in_cell  (in_cell),
        .offset   (offset)
    );

    wall_decoder u_wall_decoder (
        .pixel  (pixel),
        .maze   (maze),
        .border (border),
        .wall   (wall)
    );

    player_sprite_rom u_player_sprite_rom (
        .offset (offset),
        .sprite (sprite)
    );

    // only clocked stage
    pixel_compositor u_pixel_compositor (
        .clock     (clock),
        .reset     (reset),
        .border    (border),
        .wall      (wall),
        .in_cell   (in_cell),
        .sprite    (sprite),
        .oled_data (oled_data)
    );

endmodule

`default_nettype wire

// ==== hdl/pixel_compositor.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_compositor (
    input  wire                              clock,
    input  wire                              reset,
    input  wire maze_colour_pkg::layer_hit_t border,
    input  wire maze_colour_pkg::layer_hit_t wall,
    input  wire                              in_cell,
    input  wire maze_colour_pkg::rgb565_t    sprite,
    output maze_colour_pkg::rgb565_t         oled_data
);
    import maze_colour_pkg::*;

    rgb565_t next_colour;

    // first layer to claim the pixel wins
    always_comb begin
        if (border.hit) begin
            next_colour = border.colour;
        end else if (wall.hit) begin
            next_colour = wall.colour;
        end else if (in_cell) begin
            next_colour = sprite;
        end else begin
            // open floor
            next_colour = COLOUR_WHITE;
        end
    end

    // single pipeline stage toward the panel
    always_ff @(posedge clock) begin
        if (reset) begin
            oled_data <= COLOUR_BLACK;
        end else begin
            oled_data <= next_colour;
        end
    end

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    // panel sees black right after reset
    reset_black: assert property (@(posedge clock) reset |=> oled_data == COLOUR_BLACK)
        else $error("oled_data not black after reset");

    // frame colour from the decoder must reach the panel as black
    border_black: assert property (
        @(posedge clock) disable iff (reset)
        border.hit |=> oled_data == COLOUR_BLACK
    ) else $error("border pixel drawn as %h instead of black", oled_data);

endmodule

`default_nettype wire

// ==== hdl/player_sprite_rom.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "maze_params.svh"

module player_sprite_rom (
    input  wire maze_geometry_pkg::sprite_offset_t offset,
    output maze_colour_pkg::rgb565_t               sprite
);
    import maze_geometry_pkg::*;
    import maze_colour_pkg::*;

    // short names keep the table readable
    localparam palette_t wh = PAL_WHITE;
    localparam palette_t sk = PAL_SKIN;
    localparam palette_t hr = PAL_HAIR;
    localparam palette_t sh = PAL_SHOE;
    localparam palette_t cp = PAL_CAP;

    //////////////////////////////////////////////////
    // sprite table, row is py, column is px
    //////////////////////////////////////////////////

    localparam palette_t sprite_table [`MAZE_SPRITE_SIZE][`MAZE_SPRITE_SIZE] = '{
        '{wh, wh, wh, wh, wh, wh, wh, wh, wh, wh, wh, wh, wh, wh, wh},
        '{wh, wh, wh, wh, wh, wh, wh, wh, wh, wh, wh, wh, wh, wh, wh},
        // arms raised
        '{wh, wh, wh, wh, wh, wh, sk, sk, wh, wh, wh, sk, wh, wh, wh},
        '{wh, wh, wh, wh, wh, wh, hr, hr, hr, sk, sk, hr, wh, wh, wh},
        '{wh, wh, wh, wh, wh, wh, hr, hr, hr, sk, sk, hr, wh, wh, wh},
        // cap band
        '{wh, hr, hr, sk, sk, wh, hr, hr, cp, cp, hr, cp, cp, wh, wh},
        '{wh, hr, hr, sk, sk, wh, hr, hr, cp, cp, hr, cp, cp, wh, wh},
        '{wh, sk, sk, wh, wh, wh, hr, hr, hr, hr, hr, hr, wh, wh, wh},
        '{wh, sk, sk, wh, wh, wh, hr, hr, hr, hr, hr, hr, wh, wh, wh},
        '{wh, hr, hr, sk, sk, hr, sk, sk, hr, sk, sk, wh, wh, wh, wh},
        // body and legs
        '{wh, wh, wh, hr, hr, hr, hr, hr, hr, hr, hr, wh, wh, wh, wh},
        '{wh, wh, wh, hr, hr, hr, hr, hr, hr, hr, hr, wh, wh, wh, wh},
        // shoes
        '{wh, wh, wh, hr, hr, sh, wh, wh, hr, sh, sh, wh, wh, wh, wh},
        '{wh, wh, wh, hr, hr, sh, wh, wh, hr, sh, sh, wh, wh, wh, wh},
        '{wh, wh, wh, wh, wh, wh, wh, wh, wh, wh, wh, wh, wh, wh, wh}
    };

    palette_t index;

    // offset 15 on either axis falls outside the table
    always_comb begin
        if (offset.px < OFFSET_W'(`MAZE_SPRITE_SIZE) &&
            offset.py < OFFSET_W'(`MAZE_SPRITE_SIZE)) begin
            index = sprite_table[offset.py][offset.px];
        end else begin
            index = PAL_WHITE;
        end
    end

    // palette lookup
    always_comb begin
        case (index)
            PAL_WHITE: sprite = COLOUR_WHITE;
            PAL_BLACK: sprite = COLOUR_BLACK;
            PAL_SKIN:  sprite = COLOUR_SKIN;
            PAL_HAIR:  sprite = COLOUR_HAIR;
            PAL_SHOE:  sprite = COLOUR_SHOE;
            PAL_CAP:   sprite = COLOUR_CAP;
            default:   sprite = COLOUR_WHITE;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/wall_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "maze_params.svh"

module wall_decoder (
    input  wire maze_geometry_pkg::pixel_coord_t pixel,
    input  wire maze_geometry_pkg::maze_map_t    maze,
    output maze_colour_pkg::layer_hit_t          border,
    output maze_colour_pkg::layer_hit_t          wall
);
    import maze_colour_pkg::*;

    logic on_border;
    logic v_hit;
    logic v_bit;
    logic h_hit;
    logic h_bit;
    logic wall_bit;

    //////////////////////////////////////////////////
    // outer frame
    //////////////////////////////////////////////////

    // left and right columns, then top and bottom rows
    assign on_border =
        ((pixel.x == `MAZE_LEFT || pixel.x == `MAZE_RIGHT) &&
         pixel.y >= `MAZE_TOP && pixel.y <= `MAZE_BOTTOM) ||
        ((pixel.y == `MAZE_TOP || pixel.y == `MAZE_BOTTOM) &&
         pixel.x >= `MAZE_LEFT && pixel.x <= `MAZE_RIGHT);

    // frame is always black
    assign border = '{hit: on_border, colour: COLOUR_BLACK};

    //////////////////////////////////////////////////
    // vertical segments
    //////////////////////////////////////////////////

    // four per row band at bit 4r+k
    always_comb begin
        int lo;
        int hi;
        v_hit = 1'b0;
        v_bit = 1'b0;
        for (int r = 0; r < `MAZE_ROWS; r++) begin
            lo = `MAZE_TOP + 1 + `MAZE_PITCH * r;
            // last band stops above the bottom frame
            hi = (r == `MAZE_ROWS - 1) ? `MAZE_BOTTOM - 1 : `MAZE_TOP + `MAZE_PITCH * (r + 1);
            for (int k = 0; k < `MAZE_COLS - 1; k++) begin
                if (pixel.x == `MAZE_LEFT + `MAZE_PITCH * (k + 1) &&
                    pixel.y >= lo && pixel.y <= hi) begin
                    v_hit = 1'b1;
                    v_bit = maze[(`MAZE_COLS - 1) * r + k];
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // horizontal segments
    //////////////////////////////////////////////////

    // five per level at bit 16+5r+c
    // spans stop short of the vertical lines
    always_comb begin
        h_hit = 1'b0;
        h_bit = 1'b0;
        for (int r = 0; r < `MAZE_ROWS - 1; r++) begin
            for (int c = 0; c < `MAZE_COLS; c++) begin
                if (pixel.y == `MAZE_TOP + `MAZE_PITCH * (r + 1) &&
                    pixel.x >= `MAZE_LEFT + 1 + `MAZE_PITCH * c &&
                    pixel.x <= `MAZE_LEFT + `MAZE_PITCH * (c + 1) - 1) begin
                    h_hit = 1'b1;
                    h_bit = maze[`MAZE_VWALLS + `MAZE_COLS * r + c];
                end
            end
        end
    end

    // vertical wins where both claim a pixel
    assign wall_bit = v_hit ? v_bit : h_bit;

    // set bit means a closed wall
    assign wall = '{hit: v_hit | h_hit, colour: wall_bit ? COLOUR_BLACK : COLOUR_WHITE};

endmodule

`default_nettype wire

// ==== verification/maze_renderer_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "maze_params.svh"

module maze_renderer_tb;
    import maze_geometry_pkg::*;
    import maze_colour_pkg::*;

    // rule that decided the expected colour
    // K_NONE marks an unchecked pixel
    typedef enum logic [2:0] {K_NONE, K_BORDER, K_VWALL, K_HWALL, K_SPRITE, K_FLOOR} kind_t;

    typedef struct packed {
        kind_t   kind;
        rgb565_t colour;
    } expect_t;

    // nine raster scans plus the random tail need about 56000 cycles
    localparam int TIMEOUT_CYCLES = 60000;
    localparam int SCAN_POS [3] = '{0, 7, 19};

    logic         clock;
    logic         reset;
    pixel_coord_t pixel;
    maze_map_t    maze;
    cell_num_t    position;
    rgb565_t      oled_data;

    expect_t exp_q = '{kind: K_NONE, colour: 16'h0000};
    int      errors = 0;
    int      cycles = 0;
    int      hits [6] = '{0, 0, 0, 0, 0, 0};

    maze_renderer dut (
        .clock     (clock),
        .reset     (reset),
        .pixel     (pixel),
        .maze      (maze),
        .position  (position),
        .oled_data (oled_data)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    //////////////////////////////////////////////////
    // reference rules
    //////////////////////////////////////////////////

    function automatic expect_t reference_colour(pixel_coord_t p, maze_map_t m, cell_num_t pos);
        expect_t e;
        int      x;
        int      y;
        int      hi;
        int      px;
        int      py;
        x = p.x;
        y = p.y;
        e = '{kind: K_FLOOR, colour: 16'hffff};
        // frame
        if (((x == 11 || x == 85) && y >= 2 && y <= 61) ||
            ((y == 2 || y == 61) && x >= 11 && x <= 85)) begin
            return '{kind: K_BORDER, colour: 16'h0000};
        end
        // vertical walls
        // last band stops at row 60
        for (int r = 0; r < 4; r++) begin
            hi = (r == 3) ? 60 : 17 + 15 * r;
            for (int k = 0; k < 4; k++) begin
                if (x == 26 + 15 * k && y >= 3 + 15 * r && y <= hi) begin
                    return '{kind: K_VWALL, colour: m[4 * r + k] ? 16'h0000 : 16'hffff};
                end
            end
        end
        // horizontal walls
        for (int r = 0; r < 3; r++) begin
            for (int c = 0; c < 5; c++) begin
                if (y == 17 + 15 * r && x >= 12 + 15 * c && x <= 25 + 15 * c) begin
                    return '{kind: K_HWALL, colour: m[16 + 5 * r + c] ? 16'h0000 : 16'hffff};
                end
            end
        end
        px = x - (13 + 15 * (pos % 5));
        py = y - (3 + 15 * (pos / 5));
        if (px >= 0 && px < 15 && py >= 0 && py < 15) begin
            // only the anchor entries are known
            e.kind = K_SPRITE;
            if (px == 1 && py == 7) e.colour = 16'hcc88;
            else if (px == 1 && py == 5) e.colour = 16'hdd6e;
            else if (px == 5 && py == 12) e.colour = 16'h9346;
            else if (px == 8 && py == 5) e.colour = 16'he803;
            else if (px == 0 && py == 0) e.colour = 16'hffff;
            else e.kind = K_NONE;
        end
        return e;
    endfunction

    // expectation follows the dut by one cycle
    always @(posedge clock) begin
        cycles++;
        if (exp_q.kind != K_NONE) hits[exp_q.kind]++;
        if (reset) begin
            exp_q <= '{kind: K_NONE, colour: 16'h0000};
        end else begin
            exp_q <= reference_colour(pixel, maze, position);
        end
    end

    task automatic report_mismatch(input rgb565_t expected, input rgb565_t actual);
        errors++;
        $display("MISMATCH at %0t: oled_data expected %h, got %h", $time, expected, actual);
    endtask

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    reset_black: assert property (@(posedge clock) reset |=> oled_data == 16'h0000)
        else report_mismatch(16'h0000, $sampled(oled_data));
    border_check: assert property (@(posedge clock) disable iff (reset)
        exp_q.kind == K_BORDER |-> oled_data == exp_q.colour)
        else report_mismatch($sampled(exp_q.colour), $sampled(oled_data));
    vwall_check: assert property (@(posedge clock) disable iff (reset)
        exp_q.kind == K_VWALL |-> oled_data == exp_q.colour)
        else report_mismatch($sampled(exp_q.colour), $sampled(oled_data));
    hwall_check: assert property (@(posedge clock) disable iff (reset)
        exp_q.kind == K_HWALL |-> oled_data == exp_q.colour)
        else report_mismatch($sampled(exp_q.colour), $sampled(oled_data));
    sprite_check: assert property (@(posedge clock) disable iff (reset)
        exp_q.kind == K_SPRITE |-> oled_data == exp_q.colour)
        else report_mismatch($sampled(exp_q.colour), $sampled(oled_data));
    floor_check: assert property (@(posedge clock) disable iff (reset)
        exp_q.kind == K_FLOOR |-> oled_data == exp_q.colour)
        else report_mismatch($sampled(exp_q.colour), $sampled(oled_data));

    // new inputs 1 ns after the edge
    task automatic drive_pixel(input int x, input int y, input maze_map_t m, input cell_num_t pos);
        @(posedge clock);
        #1;
        pixel.x  = coord_t'(x);
        pixel.y  = coord_t'(y);
        maze     = m;
        position = pos;
    endtask

    task automatic scan_panel(input maze_map_t m, input cell_num_t pos);
        for (int y = 0; y < `MAZE_PANEL_H; y++) begin
            for (int x = 0; x < `MAZE_PANEL_W; x++) begin
                drive_pixel(x, y, m, pos);
            end
        end
    endtask

    initial begin
        wait (cycles >= TIMEOUT_CYCLES);
        $display("timeout: stimulus did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        maze_map_t maps [3];
        kind_t     kind;
        void'($urandom(92));
        reset    = 1'b1;
        pixel    = '0;
        maze     = '0;
        position = '0;
        // open, fully walled and one random maze
        maps[0] = '0;
        maps[1] = '1;
        maps[2] = maze_map_t'($urandom());
        repeat (8) @(posedge clock);
        #1 reset = 1'b0;
        foreach (maps[m]) begin
            foreach (SCAN_POS[i]) scan_panel(maps[m], cell_num_t'(SCAN_POS[i]));
        end
        repeat (500) begin
            drive_pixel($urandom_range(`MAZE_PANEL_W - 1), $urandom_range(`MAZE_PANEL_H - 1),
                        maps[2], cell_num_t'($urandom_range(19)));
        end
        // let the last pixel reach the panel and its check run
        repeat (2) @(posedge clock);
        #1;
        for (int k = K_BORDER; k <= K_FLOOR; k++) begin
            kind = kind_t'(k);
            if (hits[k] == 0) begin
                errors++;
                $display("no %s pixels were checked", kind.name());
            end
        end
        $display("checks: border %0d vwall %0d hwall %0d sprite %0d floor %0d, errors %0d",
                 hits[K_BORDER], hits[K_VWALL], hits[K_HWALL], hits[K_SPRITE],
                 hits[K_FLOOR], errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
